// File: rtl/fma_pkg.sv
/*
  fused multiply-add pipe shared types
  widths, fixed-point vector types, operation and rounding encodings,
  and the structs that carry a dispatched operation and an aligned addend
*/
package fma_pkg;

  // operand and result width, Q16.16 by default
  localparam int data_width = 32;
  localparam int prod_width = 2 * data_width;
  // two bits of headroom so product plus addend cannot wrap
  localparam int sum_width = prod_width + 2;

  typedef logic [data_width-1:0] word_t;
  typedef logic [prod_width-1:0] prod_t;
  typedef logic [sum_width-1:0]  sum_t;

  // fused forms first, then the single-operation forms
  typedef enum logic [3:0] {
    e_fmadd  = 4'd0,
    e_fmsub  = 4'd1,
    e_fnmsub = 4'd2,
    e_fnmadd = 4'd3,
    e_fmul   = 4'd4,
    e_fadd   = 4'd5,
    e_fsub   = 4'd6,
    e_imul   = 4'd7
  } fu_op_e;

  // dyn selects the mode held in the dynamic rounding register
  typedef enum logic [2:0] {
    e_rne = 3'd0,
    e_rtz = 3'd1,
    e_rdn = 3'd2,
    e_rup = 3'd3,
    e_rmm = 3'd4,
    e_dyn = 3'd7
  } rm_e;

  typedef struct packed {
    logic of;
    logic nx;
  } fflags_s;

  typedef struct packed {
    logic   v;
    fu_op_e fu_op;
    rm_e    rm;
    logic   mulh;
    word_t  a;
    word_t  b;
    word_t  c;
  } dispatch_s;

  // addend at product scale with its sign applied, plus what the
  // rounding stage needs to know about the product
  typedef struct packed {
    sum_t addend;
    logic neg_prod;
    rm_e  rm;
  } addend_s;

endpackage

// File: rtl/fma_mul_core.sv
/*
  fma multiplier core
  picks the multiplier operands, runs a two-stage signed 32x32 multiply
  and finishes the integer multiply path with low/high word selection
*/
`timescale 1ns/1ns

module fma_mul_core #(
  parameter int frac_bits_p = 16
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  input  fma_pkg::dispatch_s  dispatch_i,
  output fma_pkg::prod_t      prod_o,
  output logic                prod_v_o,
  output fma_pkg::word_t      imul_data_o,
  output logic                imul_v_o
);

  localparam int dw = fma_pkg::data_width;

  // 1.0 in the fixed-point format
  localparam fma_pkg::word_t one_fixed = fma_pkg::word_t'(1) << frac_bits_p;

  logic           is_imul;
  logic           is_addsub;
  fma_pkg::word_t op_b;

  // operand registers load at edge 1
  fma_pkg::word_t a_q;
  fma_pkg::word_t b_q;
  logic [1:0]     mulh_q;

  // product register loads at edge 2
  fma_pkg::prod_t prod_q;

  // integer result register loads at edge 3
  fma_pkg::word_t imul_data_q;

  // separate valid chains for the two result classes
  logic [2:0]     imul_v_q;
  logic [1:0]     fma_v_q;

  assign is_imul   = (dispatch_i.fu_op == fma_pkg::e_imul);
  assign is_addsub = (dispatch_i.fu_op == fma_pkg::e_fadd)
                   | (dispatch_i.fu_op == fma_pkg::e_fsub);

  // add and subtract run through the multiplier as a x 1.0
  assign op_b = is_addsub ? one_fixed : dispatch_i.b;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || flush_i)
    begin
      imul_v_q <= '0;
      fma_v_q  <= '0;
    end
    else
    begin
      imul_v_q <= {imul_v_q[1:0], dispatch_i.v & is_imul};
      fma_v_q  <= {fma_v_q[0], dispatch_i.v & ~is_imul};
    end
  end

  always_ff @(posedge clk_i)
  begin
    a_q    <= dispatch_i.a;
    b_q    <= op_b;
    mulh_q <= {mulh_q[0], dispatch_i.mulh};
  end

  // operands widened with their sign so the product keeps all 64 bits
  always_ff @(posedge clk_i)
  begin
    prod_q <= $signed({{dw{a_q[dw-1]}}, a_q}) * $signed({{dw{b_q[dw-1]}}, b_q});
  end

  always_ff @(posedge clk_i)
  begin
    if (mulh_q[1])
      imul_data_q <= prod_q[2*dw-1:dw];
    else
      imul_data_q <= prod_q[dw-1:0];
  end

  assign prod_o      = prod_q;
  assign prod_v_o    = fma_v_q[1];
  assign imul_data_o = imul_data_q;
  assign imul_v_o    = imul_v_q[2];

  // the decoder must never hand the pipe an undefined operation
  a_legal_op : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dispatch_i.v |-> dispatch_i.fu_op inside {fma_pkg::e_fmadd, fma_pkg::e_fmsub,
                                              fma_pkg::e_fnmsub, fma_pkg::e_fnmadd,
                                              fma_pkg::e_fmul, fma_pkg::e_fadd,
                                              fma_pkg::e_fsub, fma_pkg::e_imul});

endmodule

// File: rtl/fma_addend_align.sv
/*
  fma addend alignment
  selects the addend, moves it to product scale with its sign applied,
  resolves the rounding mode at issue and delays all of it to meet the product
*/
`timescale 1ns/1ns

module fma_addend_align #(
  parameter int frac_bits_p = 16
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  input  fma_pkg::dispatch_s  dispatch_i,
  input  fma_pkg::rm_e        frm_dyn_i,
  output fma_pkg::addend_s    addend_o
);

  localparam int dw = fma_pkg::data_width;
  localparam int sw = fma_pkg::sum_width;

  fma_pkg::word_t   addend_sel;
  fma_pkg::sum_t    addend_ext;
  fma_pkg::sum_t    addend_scaled;
  logic             neg_addend;
  logic             issue_v;
  fma_pkg::addend_s addend_d;
  fma_pkg::addend_s stage1_q;
  fma_pkg::addend_s stage2_q;
  logic [1:0]       v_q;

  assign issue_v = dispatch_i.v & (dispatch_i.fu_op != fma_pkg::e_imul);

  always_comb
  begin
    case (dispatch_i.fu_op)
      fma_pkg::e_fadd, fma_pkg::e_fsub: addend_sel = dispatch_i.b;
      fma_pkg::e_fmul:                  addend_sel = '0;
      default:                          addend_sel = dispatch_i.c;
    endcase
  end

  assign neg_addend = (dispatch_i.fu_op == fma_pkg::e_fmsub)
                    | (dispatch_i.fu_op == fma_pkg::e_fsub)
                    | (dispatch_i.fu_op == fma_pkg::e_fnmadd);

  // sign-extend, then shift up so the binary point lines up with the product
  assign addend_ext    = {{(sw-dw){addend_sel[dw-1]}}, addend_sel};
  assign addend_scaled = addend_ext << frac_bits_p;

  always_comb
  begin
    addend_d.addend   = neg_addend ? fma_pkg::sum_t'(-addend_scaled) : addend_scaled;
    addend_d.neg_prod = (dispatch_i.fu_op == fma_pkg::e_fnmsub)
                      | (dispatch_i.fu_op == fma_pkg::e_fnmadd);
    // dyn is bound here so later writes to the dynamic mode miss this op
    addend_d.rm       = (dispatch_i.rm == fma_pkg::e_dyn) ? frm_dyn_i : dispatch_i.rm;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || flush_i)
      v_q <= '0;
    else
      v_q <= {v_q[0], issue_v};
  end

  // stages only load when a fused op passes through
  always_ff @(posedge clk_i)
  begin
    if (issue_v)
      stage1_q <= addend_d;
    if (v_q[0])
      stage2_q <= stage1_q;
  end

  assign addend_o = stage2_q;

  a_rm_resolved : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    v_q[1] |-> addend_o.rm inside {fma_pkg::e_rne, fma_pkg::e_rtz, fma_pkg::e_rdn,
                                   fma_pkg::e_rup, fma_pkg::e_rmm});

endmodule

// File: rtl/fma_round_sat.sv
/*
  fma round and saturate
  adds the product and aligned addend, rounds the magnitude back to the
  fixed-point format under the op's mode, saturates on overflow and
  registers the result and flags over two stages
*/
`timescale 1ns/1ns

module fma_round_sat #(
  parameter int frac_bits_p = 16
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               flush_i,
  input  fma_pkg::prod_t     prod_i,
  input  logic               prod_v_i,
  input  fma_pkg::addend_s   addend_i,
  output fma_pkg::word_t     fma_data_o,
  output fma_pkg::fflags_s   fma_fflags_o,
  output logic               fma_v_o
);

  localparam int dw = fma_pkg::data_width;
  localparam int pw = fma_pkg::prod_width;
  localparam int sw = fma_pkg::sum_width;

  localparam fma_pkg::word_t word_max = {1'b0, {(dw-1){1'b1}}};
  localparam fma_pkg::word_t word_min = {1'b1, {(dw-1){1'b0}}};

  fma_pkg::sum_t          prod_ext;
  fma_pkg::sum_t          prod_term;
  fma_pkg::sum_t          sum;
  logic                   sign;
  fma_pkg::sum_t          mag;
  fma_pkg::sum_t          mag_sh;
  logic [frac_bits_p-1:0] dropped;
  logic                   half;
  logic                   sticky;
  logic                   inc;
  fma_pkg::sum_t          rounded;
  logic                   ovf;
  fma_pkg::word_t         res_mag;
  fma_pkg::word_t         result;
  fma_pkg::fflags_s       flags;

  fma_pkg::word_t         data_q;
  fma_pkg::fflags_s       flags_q;
  fma_pkg::word_t         data_qq;
  fma_pkg::fflags_s       flags_qq;
  logic [1:0]             v_q;

  assign prod_ext  = {{(sw-pw){prod_i[pw-1]}}, prod_i};
  assign prod_term = addend_i.neg_prod ? fma_pkg::sum_t'(-prod_ext) : prod_ext;
  assign sum       = prod_term + addend_i.addend;

  // rounding works on the magnitude so the modes read directly
  assign sign   = sum[sw-1];
  assign mag    = sign ? fma_pkg::sum_t'(-sum) : sum;
  assign mag_sh = mag >> frac_bits_p;

  assign dropped = mag[frac_bits_p-1:0];
  assign half    = dropped[frac_bits_p-1];
  assign sticky  = |dropped[frac_bits_p-2:0];

  always_comb
  begin
    case (addend_i.rm)
      // ties go to the even neighbour
      fma_pkg::e_rne: inc = half & (sticky | mag_sh[0]);
      fma_pkg::e_rtz: inc = 1'b0;
      fma_pkg::e_rdn: inc = sign & (half | sticky);
      fma_pkg::e_rup: inc = ~sign & (half | sticky);
      fma_pkg::e_rmm: inc = half;
      default:        inc = 1'b0;
    endcase
  end

  assign rounded = mag_sh + fma_pkg::sum_t'(inc);

  // negative side reaches one step further than the positive side
  assign ovf = sign ? (rounded > fma_pkg::sum_t'(word_min))
                    : (rounded[sw-1:dw-1] != '0);

  assign res_mag = rounded[dw-1:0];

  always_comb
  begin
    if (ovf)
      result = sign ? word_min : word_max;
    else if (sign)
      result = fma_pkg::word_t'(-res_mag);
    else
      result = res_mag;
    flags.of = ovf;
    flags.nx = ovf | (|dropped);
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || flush_i)
      v_q <= '0;
    else
      v_q <= {v_q[0], prod_v_i};
  end

  always_ff @(posedge clk_i)
  begin
    data_q   <= result;
    flags_q  <= flags;
    data_qq  <= data_q;
    flags_qq <= flags_q;
  end

  assign fma_data_o   = data_qq;
  assign fma_fflags_o = flags_qq;
  assign fma_v_o      = v_q[1];

  // an overflowed result has to leave the pipe pinned at a rail
  a_sat_rail : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (fma_v_o && fma_fflags_o.of) |-> (fma_data_o == word_max || fma_data_o == word_min));

endmodule

// File: rtl/fma_pipe.sv
/*
  fused multiply-add execution pipe, Q16.16 fixed point
  integer multiply results leave after 3 cycles, fused results with
  rounding and flags after 4, one new op may issue every cycle
*/
`timescale 1ns/1ns

module fma_pipe #(
  parameter int frac_bits_p = 16
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  input  fma_pkg::dispatch_s  dispatch_i,
  input  fma_pkg::rm_e        frm_dyn_i,
  output fma_pkg::word_t      imul_data_o,
  output logic                imul_v_o,
  output fma_pkg::word_t      fma_data_o,
  output fma_pkg::fflags_s    fma_fflags_o,
  output logic                fma_v_o
);

  fma_pkg::prod_t   prod;
  logic             prod_v;
  fma_pkg::addend_s addend;

  // multiplier and addend paths run side by side and meet at edge 2
  fma_mul_core #(
    .frac_bits_p (frac_bits_p)
  ) u_mul_core (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .dispatch_i  (dispatch_i),
    .prod_o      (prod),
    .prod_v_o    (prod_v),
    .imul_data_o (imul_data_o),
    .imul_v_o    (imul_v_o)
  );

  fma_addend_align #(
    .frac_bits_p (frac_bits_p)
  ) u_addend_align (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .dispatch_i  (dispatch_i),
    .frm_dyn_i   (frm_dyn_i),
    .addend_o    (addend)
  );

  fma_round_sat #(
    .frac_bits_p (frac_bits_p)
  ) u_round_sat (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .prod_i       (prod),
    .prod_v_i     (prod_v),
    .addend_i     (addend),
    .fma_data_o   (fma_data_o),
    .fma_fflags_o (fma_fflags_o),
    .fma_v_o      (fma_v_o)
  );

endmodule

// File: sim/tb_fma_pipe.sv
/*
  testbench for the fused multiply-add pipe
  issues random dispatches from an xorshift generator, predicts every
  integer and fused result with a wide-integer model, and checks value,
  flags and latency of each result, including flush behavior
*/
`timescale 1ns/1ns

module tb_fma_pipe;

  localparam int frac_bits     = 16;
  localparam int op_count      = 3000;
  localparam int cycle_limit   = 20000;
  localparam int drain_timeout = 50;

  // expected result tagged with the edge that sampled its dispatch
  typedef struct packed {
    logic [31:0]      edge_no;
    fma_pkg::word_t   data;
    fma_pkg::fflags_s flags;
  } exp_s;

  logic               clk;
  logic               rst_n;
  logic               flush;
  fma_pkg::dispatch_s disp;
  fma_pkg::rm_e       frm_dyn;
  fma_pkg::word_t     imul_data;
  logic               imul_v;
  fma_pkg::word_t     fma_data;
  fma_pkg::fflags_s   fma_fflags;
  logic               fma_v;

  logic [31:0] rng_state = 32'hb382_aba5;
  logic [31:0] edge_cnt = '0;
  int          issued = 0;
  int          cycles = 0;
  int          wait_cnt = 0;
  exp_s        imul_q[$];
  exp_s        fma_q[$];

  fma_pipe #(
    .frac_bits_p (frac_bits)
  ) DUT (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .flush_i      (flush),
    .dispatch_i   (disp),
    .frm_dyn_i    (frm_dyn),
    .imul_data_o  (imul_data),
    .imul_v_o     (imul_v),
    .fma_data_o   (fma_data),
    .fma_fflags_o (fma_fflags),
    .fma_v_o      (fma_v)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
    edge_cnt <= edge_cnt + 32'd1;

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // small operands stay within +-8.0, the rest use the whole range
  function automatic fma_pkg::word_t shape_operand(logic [31:0] r, logic [31:0] sel);
    if (sel % 32'd4 == 32'd0)
      return r;
    return {{12{r[19]}}, r[19:0]};
  endfunction

  function automatic fma_pkg::word_t imul_model(fma_pkg::word_t a, fma_pkg::word_t b,
                                                logic mulh);
    logic signed [127:0] a_x;
    logic signed [127:0] b_x;
    logic signed [127:0] prod;
    a_x  = {{96{a[31]}}, a};
    b_x  = {{96{b[31]}}, b};
    prod = a_x * b_x;
    return mulh ? prod[63:32] : prod[31:0];
  endfunction

  // exact value, then floor division with a remainder that picks the neighbour
  function automatic exp_s fused_model(fma_pkg::fu_op_e op, fma_pkg::rm_e rm,
                                       fma_pkg::word_t a, fma_pkg::word_t b,
                                       fma_pkg::word_t c);
    logic signed [127:0] one;
    logic signed [127:0] half;
    logic signed [127:0] a_x;
    logic signed [127:0] m_x;
    logic signed [127:0] add_x;
    logic signed [127:0] prod;
    logic signed [127:0] s;
    logic signed [127:0] q;
    logic signed [127:0] r;
    logic signed [127:0] res;
    exp_s                out;
    one   = 128'sd1 <<< frac_bits;
    half  = one >>> 1;
    a_x   = {{96{a[31]}}, a};
    m_x   = (op == fma_pkg::e_fadd || op == fma_pkg::e_fsub) ? one : {{96{b[31]}}, b};
    case (op)
      fma_pkg::e_fadd, fma_pkg::e_fsub: add_x = {{96{b[31]}}, b};
      fma_pkg::e_fmul:                  add_x = '0;
      default:                          add_x = {{96{c[31]}}, c};
    endcase
    prod  = a_x * m_x;
    add_x = add_x <<< frac_bits;
    case (op)
      fma_pkg::e_fmsub, fma_pkg::e_fsub: s = prod - add_x;
      fma_pkg::e_fnmsub:                 s = add_x - prod;
      fma_pkg::e_fnmadd:                 s = -prod - add_x;
      default:                           s = prod + add_x;
    endcase
    q   = s >>> frac_bits;
    r   = s - (q <<< frac_bits);
    res = q;
    if (r != '0)
    begin
      case (rm)
        fma_pkg::e_rne: if (r > half || (r == half && q[0])) res = q + 128'sd1;
        fma_pkg::e_rtz: if (s < 128'sd0) res = q + 128'sd1;
        fma_pkg::e_rup: res = q + 128'sd1;
        fma_pkg::e_rmm: if (r > half || (r == half && s >= 128'sd0)) res = q + 128'sd1;
        default:        res = q;
      endcase
    end
    out.edge_no  = '0;
    out.flags.of = 1'b1;
    if (res > 128'sd2147483647)
      out.data = 32'h7fff_ffff;
    else if (res < -128'sd2147483648)
      out.data = 32'h8000_0000;
    else
    begin
      out.data     = res[31:0];
      out.flags.of = 1'b0;
    end
    out.flags.nx = out.flags.of | (r != '0);
    return out;
  endfunction

  task automatic abort_run(string msg);
    $display("error at time %0t: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "simulation stopped");
    end
  endtask

  // runs at the falling edge, where the outputs of the last rising edge are stable
  task automatic check_outputs();
    exp_s e;
    if (imul_v)
    begin
      if (imul_q.size() == 0)
        abort_run("imul_v_o rose with no integer multiply outstanding");
      e = imul_q.pop_front();
      check_equal("imul latency", 64'(edge_cnt), 64'(e.edge_no + 32'd2));
      check_equal("imul_data_o", 64'(imul_data), 64'(e.data));
    end
    else if (imul_q.size() > 0 && imul_q[0].edge_no + 32'd2 <= edge_cnt)
      abort_run("an integer multiply result never appeared");
    if (fma_v)
    begin
      if (fma_q.size() == 0)
        abort_run("fma_v_o rose with no fused operation outstanding");
      e = fma_q.pop_front();
      check_equal("fma latency", 64'(edge_cnt), 64'(e.edge_no + 32'd3));
      check_equal("fma_data_o", 64'(fma_data), 64'(e.data));
      check_equal("fma_fflags_o", 64'(fma_fflags), 64'(e.flags));
    end
    else if (fma_q.size() > 0 && fma_q[0].edge_no + 32'd3 <= edge_cnt)
      abort_run("a fused result never appeared");
  endtask

  task automatic drive_next();
    logic [31:0]  r;
    logic [31:0]  idx;
    logic [31:0]  issue_edge;
    fma_pkg::rm_e rm_res;
    exp_s         e;
    issue_edge  = edge_cnt + 32'd1;
    r           = next_rand();
    disp.v      = (r % 32'd10) < 32'd8;
    disp.mulh   = r[20];
    r           = next_rand();
    disp.fu_op  = fma_pkg::fu_op_e'({1'b0, r[2:0]});
    idx         = r % 32'd6;
    disp.rm     = (idx == 32'd5) ? fma_pkg::e_dyn : fma_pkg::rm_e'(idx[2:0]);
    idx         = (r >> 8) % 32'd5;
    frm_dyn     = fma_pkg::rm_e'(idx[2:0]);
    flush       = ((r >> 16) % 32'd64) == 32'd0;
    disp.a      = shape_operand(next_rand(), next_rand());
    disp.b      = shape_operand(next_rand(), next_rand());
    disp.c      = shape_operand(next_rand(), next_rand());
    if (disp.v)
    begin
      issued++;
      rm_res = (disp.rm == fma_pkg::e_dyn) ? frm_dyn : disp.rm;
      if (disp.fu_op == fma_pkg::e_imul)
      begin
        e.edge_no = issue_edge;
        e.data    = imul_model(disp.a, disp.b, disp.mulh);
        e.flags   = '0;
        imul_q.push_back(e);
      end
      else
      begin
        e         = fused_model(disp.fu_op, rm_res, disp.a, disp.b, disp.c);
        e.edge_no = issue_edge;
        fma_q.push_back(e);
      end
    end
    // a flush kills every op whose result would show at or after its edge
    if (flush)
    begin
      while (imul_q.size() > 0 && imul_q[imul_q.size()-1].edge_no + 32'd2 >= issue_edge)
        imul_q.delete(imul_q.size() - 1);
      while (fma_q.size() > 0 && fma_q[fma_q.size()-1].edge_no + 32'd3 >= issue_edge)
        fma_q.delete(fma_q.size() - 1);
    end
  endtask

  initial
  begin
    rst_n   = 1'b0;
    flush   = 1'b0;
    frm_dyn = fma_pkg::e_rne;
    disp    = '0;
    // a valid op held during reset must never come out
    disp.v  = 1'b1;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    check_equal("imul_v_o after reset", 64'(imul_v), 64'd0);
    check_equal("fma_v_o after reset", 64'(fma_v), 64'd0);
    drive_next();

    while (issued < op_count)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > cycle_limit)
        abort_run("stimulus ran past its cycle limit before all operations issued");
      check_outputs();
      drive_next();
    end

    while ((imul_q.size() > 0 || fma_q.size() > 0) && wait_cnt < drain_timeout)
    begin
      @(negedge clk);
      check_outputs();
      disp.v = 1'b0;
      flush  = 1'b0;
      wait_cnt++;
    end

    if (imul_q.size() == 0 && fma_q.size() == 0)
    begin
      $display("TB PASSED");
      $finish;
    end
    else
    begin
      $display("drain timed out with %0d imul and %0d fused results outstanding",
               imul_q.size(), fma_q.size());
      $display("TB FAILED");
      $fatal(1, "simulation stopped");
    end
  end

endmodule

// File: src.f
rtl/fma_pkg.sv
rtl/fma_mul_core.sv
rtl/fma_addend_align.sv
rtl/fma_round_sat.sv
rtl/fma_pipe.sv
sim/tb_fma_pipe.sv

// File: run.sh
#!/bin/sh
# build the fma pipe testbench with verilator and run it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_fma_pipe -f src.f -o tb_fma_pipe

out=$(./obj_dir/tb_fma_pipe) || true
echo "$out"
if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
